// File: rtl/adc_lvds_pkg.sv
`default_nettype none

package adc_lvds_pkg;

   // --------------------
   // sample word and lane geometry
   localparam int word_w       = 16;   // one adc sample
   localparam int lanes_per_ch = 2;    // lvds lanes per channel
   localparam int bits_per_clk = 4;    // 2 lanes x (even + odd) per dclk

   // --------------------
   // word assembly
   localparam int shift_w = 16;        // depth of each lane shift register
   localparam int pick_hi = 11;        // shift index of the msb nibble
   localparam int pick_lo = 8;         // shift index of the lsb nibble

   // --------------------
   // frame clock
   localparam int fclk_sync_stages = 3;   // edge judged between last two stages

   typedef logic [word_w-1:0] word_t;     // sample word, same for cha and chb

endpackage

`default_nettype wire

// File: rtl/frame_edge_decode.sv
`timescale 1ns/1ps
`default_nettype none

module frame_edge_decode (
   input  logic adc_dclk,     // divided bit clock from the adc
   input  logic rst,          // sync, active high
   input  logic fclk_i,       // frame clock, toggles once per word
   output logic rise_o,       // one-cycle strobe on fclk low->high
   output logic fall_o        // one-cycle strobe on fclk high->low
);

   // [0] is the first stage, top bit the last
   logic [adc_lvds_pkg::fclk_sync_stages-1:0] fclk_q;

   // --------------------
   // frame clock delay line
   always_ff @(posedge adc_dclk) begin
      if (rst) begin
         fclk_q <= '0;                        // idle low
      end else begin
         fclk_q <= {fclk_q[adc_lvds_pkg::fclk_sync_stages-2:0], fclk_i};
      end
   end

   // --------------------
   // edge decode, stage 2 against stage 3
   assign rise_o = fclk_q[adc_lvds_pkg::fclk_sync_stages-2]
                 & ~fclk_q[adc_lvds_pkg::fclk_sync_stages-1];   // new high, old low
   assign fall_o = ~fclk_q[adc_lvds_pkg::fclk_sync_stages-2]
                 & fclk_q[adc_lvds_pkg::fclk_sync_stages-1];    // new low, old high

   // strobes never coincide, and fclk never toggles on consecutive cycles
   assert property (@(posedge adc_dclk) disable iff (rst)
      (rise_o || fall_o) |-> !(rise_o && fall_o) ##1 !(rise_o || fall_o))
      else $error("frame_edge_decode: overlapping or back-to-back frame strobes");

endmodule

`default_nettype wire

// File: rtl/lane_word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module lane_word_assembler (
   input  logic                adc_dclk,   // divided bit clock
   input  logic                rst,        // sync, active high
   input  logic                l0_e_i,     // lane0, rising-edge bit
   input  logic                l0_o_i,     // lane0, falling-edge bit
   input  logic                l1_e_i,     // lane1, rising-edge bit
   input  logic                l1_o_i,     // lane1, falling-edge bit
   output adc_lvds_pkg::word_t word_o      // assembled sample, registered
);

   logic [adc_lvds_pkg::lanes_per_ch-1:0] lane_e;   // even bits, index = lane
   logic [adc_lvds_pkg::lanes_per_ch-1:0] lane_o;   // odd bits, index = lane

   logic [adc_lvds_pkg::shift_w-1:0] sr_e [adc_lvds_pkg::lanes_per_ch];  // even history
   logic [adc_lvds_pkg::shift_w-1:0] sr_o [adc_lvds_pkg::lanes_per_ch];  // odd history

   adc_lvds_pkg::word_t word_d;                     // interleaved pick, before the register

   assign lane_e = {l1_e_i, l0_e_i};
   assign lane_o = {l1_o_i, l0_o_i};

   // --------------------
   // bit history, newest bit at index 0
   always_ff @(posedge adc_dclk) begin
      for (int l = 0; l < adc_lvds_pkg::lanes_per_ch; l++) begin
         sr_e[l] <= {sr_e[l][adc_lvds_pkg::shift_w-2:0], lane_e[l]};
         sr_o[l] <= {sr_o[l][adc_lvds_pkg::shift_w-2:0], lane_o[l]};
      end
   end

   // --------------------
   // interleave
   // each shift index gives one nibble {l1_e, l0_e, l1_o, l0_o};
   // pick_hi is the oldest nibble of the word and lands in the msbs
   always_comb begin
      word_d = '0;
      for (int n = 0; n <= adc_lvds_pkg::pick_hi - adc_lvds_pkg::pick_lo; n++) begin
         for (int l = 0; l < adc_lvds_pkg::lanes_per_ch; l++) begin
            // even bits fill the upper half of the nibble
            word_d[n*adc_lvds_pkg::bits_per_clk + adc_lvds_pkg::lanes_per_ch + l] =
               sr_e[l][adc_lvds_pkg::pick_lo + n];
            // odd bits fill the lower half
            word_d[n*adc_lvds_pkg::bits_per_clk + l] =
               sr_o[l][adc_lvds_pkg::pick_lo + n];
         end
      end
   end

   // --------------------
   // output register
   // word is complete one cycle after its last nibble reaches pick_lo
   always_ff @(posedge adc_dclk) begin
      if (rst) begin
         word_o <= '0;
      end else begin
         word_o <= word_d;                    // updated every cycle, strobe picks it
      end
   end

endmodule

`default_nettype wire

// File: rtl/frame_word_result.sv
`timescale 1ns/1ps
`default_nettype none

module frame_word_result (
   input  logic                adc_dclk,   // divided bit clock
   input  logic                rst,        // sync, active high
   input  logic                rise_i,     // fclk rising-edge strobe
   input  logic                fall_i,     // fclk falling-edge strobe
   input  adc_lvds_pkg::word_t word_a_i,   // cha assembled word
   input  adc_lvds_pkg::word_t word_b_i,   // chb assembled word
   output adc_lvds_pkg::word_t data_a_o,   // cha sample, holds between pulses
   output adc_lvds_pkg::word_t data_b_o,   // chb sample, holds between pulses
   output logic                valid_o     // one cycle per frame edge
);

   adc_lvds_pkg::word_t rise_a_q;   // cha word taken on fclk rise
   adc_lvds_pkg::word_t rise_b_q;   // chb word taken on fclk rise
   adc_lvds_pkg::word_t fall_a_q;   // cha word taken on fclk fall
   adc_lvds_pkg::word_t fall_b_q;   // chb word taken on fclk fall
   logic                last_rise_q;   // output select, 1 = rise registers
   logic                valid_q;

   // --------------------
   // rising-edge capture
   always_ff @(posedge adc_dclk) begin
      if (rst) begin
         rise_a_q <= '0;
         rise_b_q <= '0;
      end else if (rise_i) begin
         rise_a_q <= word_a_i;
         rise_b_q <= word_b_i;
      end
   end

   // --------------------
   // falling-edge capture
   always_ff @(posedge adc_dclk) begin
      if (rst) begin
         fall_a_q <= '0;
         fall_b_q <= '0;
      end else if (fall_i) begin
         fall_a_q <= word_a_i;
         fall_b_q <= word_b_i;
      end
   end

   // --------------------
   // output select and valid
   always_ff @(posedge adc_dclk) begin
      if (rst) begin
         last_rise_q <= 1'b0;                 // fall registers, both zero after reset
         valid_q     <= 1'b0;
      end else begin
         if (rise_i || fall_i) begin
            last_rise_q <= rise_i;            // follow the edge just captured
         end
         valid_q <= rise_i || fall_i;         // same cycle as the data update
      end
   end

   // ping-pong read, data moves only with a strobe
   assign data_a_o = last_rise_q ? rise_a_q : fall_a_q;
   assign data_b_o = last_rise_q ? rise_b_q : fall_b_q;
   assign valid_o  = valid_q;

   // frame edges are at least a word apart, so valid is a single pulse
   assert property (@(posedge adc_dclk) disable iff (rst)
      valid_o |=> !valid_o)
      else $error("frame_word_result: valid_o high on consecutive cycles");

   // data never moves without a valid pulse
   assert property (@(posedge adc_dclk) disable iff (rst)
      !($stable(data_a_o) && $stable(data_b_o)) |-> valid_o)
      else $error("frame_word_result: output data changed without valid_o");

endmodule

`default_nettype wire

// File: rtl/adc3663_lvds_rx.sv
`timescale 1ns/1ps
`default_nettype none

module adc3663_lvds_rx (
   input  logic                adc_dclk,     // divided bit clock from the adc
   input  logic                rst,          // sync, active high
   input  logic                fclk_i,       // frame clock
   // cha lanes, already split by the ddr input cell
   input  logic                da0_e_i,
   input  logic                da0_o_i,
   input  logic                da1_e_i,
   input  logic                da1_o_i,
   // chb lanes
   input  logic                db0_e_i,
   input  logic                db0_o_i,
   input  logic                db1_e_i,
   input  logic                db1_o_i,
   output adc_lvds_pkg::word_t data_cha_o,
   output adc_lvds_pkg::word_t data_chb_o,
   output logic                valid_o
);

   logic                rise;     // fclk rising strobe
   logic                fall;     // fclk falling strobe
   adc_lvds_pkg::word_t word_a;   // cha assembled word
   adc_lvds_pkg::word_t word_b;   // chb assembled word

   // --------------------
   // decode
   frame_edge_decode i_frame_edge_decode (
      .adc_dclk (adc_dclk),
      .rst      (rst),
      .fclk_i   (fclk_i),
      .rise_o   (rise),
      .fall_o   (fall)
   );

   // --------------------
   // execute, one assembler per channel
   lane_word_assembler i_lane_word_assembler_cha (
      .adc_dclk (adc_dclk),
      .rst      (rst),
      .l0_e_i   (da0_e_i),
      .l0_o_i   (da0_o_i),
      .l1_e_i   (da1_e_i),
      .l1_o_i   (da1_o_i),
      .word_o   (word_a)
   );

   lane_word_assembler i_lane_word_assembler_chb (
      .adc_dclk (adc_dclk),
      .rst      (rst),
      .l0_e_i   (db0_e_i),
      .l0_o_i   (db0_o_i),
      .l1_e_i   (db1_e_i),
      .l1_o_i   (db1_o_i),
      .word_o   (word_b)
   );

   // --------------------
   // result
   frame_word_result i_frame_word_result (
      .adc_dclk (adc_dclk),
      .rst      (rst),
      .rise_i   (rise),
      .fall_i   (fall),
      .word_a_i (word_a),
      .word_b_i (word_b),
      .data_a_o (data_cha_o),
      .data_b_o (data_chb_o),
      .valid_o  (valid_o)
   );

endmodule

`default_nettype wire

// File: verification/adc3663_lvds_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc3663_lvds_rx_tb;

   // --------------------
   // test constants
   localparam int          tbl_n          = 32;          // word pairs in the table
   localparam int          fixed_n        = 20;          // hand-written entries before the lfsr ones
   localparam int          n_words        = tbl_n + 2;   // two zero words flush the tail
   localparam logic [31:0] seed           = 32'hd98c;
   localparam int          reset_cycles   = 16;
   localparam int          clk_period     = 40;          // ns
   localparam int          latency        = 10;          // last nibble to valid data
   localparam int          timeout_cycles = reset_cycles + 4*tbl_n + 64;

   logic                adc_dclk;
   logic                rst;
   logic                fclk_i;
   logic                da0_e_i;
   logic                da0_o_i;
   logic                da1_e_i;
   logic                da1_o_i;
   logic                db0_e_i;
   logic                db0_o_i;
   logic                db1_e_i;
   logic                db1_o_i;
   adc_lvds_pkg::word_t data_cha_o;
   adc_lvds_pkg::word_t data_chb_o;
   logic                valid_o;

   adc_lvds_pkg::word_t tbl_a [tbl_n];    // cha words, also the expected cha data
   adc_lvds_pkg::word_t tbl_b [tbl_n];    // chb words
   int                  word_end [tbl_n]; // cycle that sampled each last nibble

   adc_lvds_pkg::word_t exp_a_q [$];      // expected data per pulse
   adc_lvds_pkg::word_t exp_b_q [$];
   int                  chg_q [$];        // cycles of fclk changes not yet answered

   adc_lvds_pkg::word_t last_a = '0;      // data expected since the last pulse
   adc_lvds_pkg::word_t last_b = '0;
   logic                prev_valid = 1'b0;
   int                  cyc = 0;          // rising edges so far
   int                  pulses = 0;
   int                  changes = 0;
   int                  data_errors = 0;
   int                  timing_errors = 0;
   int                  protocol_errors = 0;

   adc3663_lvds_rx i_adc3663_lvds_rx (
      .adc_dclk   (adc_dclk),
      .rst        (rst),
      .fclk_i     (fclk_i),
      .da0_e_i    (da0_e_i),
      .da0_o_i    (da0_o_i),
      .da1_e_i    (da1_e_i),
      .da1_o_i    (da1_o_i),
      .db0_e_i    (db0_e_i),
      .db0_o_i    (db0_o_i),
      .db1_e_i    (db1_e_i),
      .db1_o_i    (db1_o_i),
      .data_cha_o (data_cha_o),
      .data_chb_o (data_chb_o),
      .valid_o    (valid_o)
   );

   initial begin
      adc_dclk = 1'b0;
      forever #(clk_period/2) adc_dclk = ~adc_dclk;
   end

   always @(posedge adc_dclk) cyc <= cyc + 1;

   // --------------------
   // stimulus helpers
   // right-shifting x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic build_table();
      logic [31:0] s;
      s = seed;
      for (int i = 0; i < 16; i++) begin
         tbl_a[i] = 16'h0001 << i;   // walking one from the lsb up
         tbl_b[i] = 16'h8000 >> i;   // other channel walks down
      end
      tbl_a[16] = 16'h0000;
      tbl_b[16] = 16'h0000;
      tbl_a[17] = 16'hffff;
      tbl_b[17] = 16'hffff;
      tbl_a[18] = 16'haaaa;          // alternating with opposite phase per channel
      tbl_b[18] = 16'h5555;
      tbl_a[19] = 16'h5555;
      tbl_b[19] = 16'haaaa;
      for (int i = fixed_n; i < tbl_n; i++) begin
         tbl_a[i] = '0;
         tbl_b[i] = '0;
         for (int k = 0; k < adc_lvds_pkg::word_w; k++) begin
            s = lfsr_next(s);
            tbl_a[i] = {tbl_a[i][14:0], s[0]};   // one step per bit
         end
         for (int k = 0; k < adc_lvds_pkg::word_w; k++) begin
            s = lfsr_next(s);
            tbl_b[i] = {tbl_b[i][14:0], s[0]};
         end
      end
   endtask

   // four nibbles msb first as {l1 even, l0 even, l1 odd, l0 odd}
   task automatic send_word(input adc_lvds_pkg::word_t a, input adc_lvds_pkg::word_t b,
                            output int last_cyc);
      logic [3:0] na;
      logic [3:0] nb;
      last_cyc = 0;
      for (int n = 0; n < 4; n++) begin
         @(negedge adc_dclk);
         na = a[15 - 4*n -: 4];
         nb = b[15 - 4*n -: 4];
         da1_e_i = na[3];
         da0_e_i = na[2];
         da1_o_i = na[1];
         da0_o_i = na[0];
         db1_e_i = nb[3];
         db0_e_i = nb[2];
         db1_o_i = nb[1];
         db0_o_i = nb[0];
         if (n == 3) begin
            fclk_i   = ~fclk_i;             // frame edge rides on the last nibble
            last_cyc = cyc + 1;             // edge that samples it
            chg_q.push_back(last_cyc);
            changes++;
         end
      end
   endtask

   // --------------------
   // pulse checker
   task automatic check_pulse();
      adc_lvds_pkg::word_t ea;
      adc_lvds_pkg::word_t eb;
      int                  due;
      if (exp_a_q.size() == 0) begin
         protocol_errors++;
         $display("unexpected valid pulse at %0t, every word was already delivered", $time);
      end else begin
         ea = exp_a_q.pop_front();
         eb = exp_b_q.pop_front();
         if (data_cha_o !== ea) begin
            data_errors++;
            $display("[ERROR] %0t data_cha_o expected %h got %h", $time, ea, data_cha_o);
         end
         if (data_chb_o !== eb) begin
            data_errors++;
            $display("[ERROR] %0t data_chb_o expected %h got %h", $time, eb, data_chb_o);
         end
         due = chg_q.pop_front() + 2;       // strobe two cycles after the change
         if (cyc != due) begin
            timing_errors++;
            $display("[ERROR] %0t valid_o cycle expected %0d got %0d", $time, due, cyc);
         end
         if (pulses >= 2 && cyc - word_end[pulses-2] != latency) begin
            timing_errors++;
            $display("[ERROR] %0t data_cha_o latency expected %0d got %0d", $time,
                     latency, cyc - word_end[pulses-2]);
         end
         last_a = ea;
         last_b = eb;
      end
      pulses++;
   endtask

   always @(negedge adc_dclk) begin
      if (cyc > reset_cycles) begin
         if (valid_o) begin
            if (prev_valid) begin
               protocol_errors++;
               $display("valid_o stayed high for two cycles at %0t", $time);
            end
            check_pulse();
         end else begin
            if (data_cha_o !== last_a) begin   // data holds between pulses
               data_errors++;
               $display("[ERROR] %0t data_cha_o expected %h got %h", $time, last_a, data_cha_o);
            end
            if (data_chb_o !== last_b) begin
               data_errors++;
               $display("[ERROR] %0t data_chb_o expected %h got %h", $time, last_b, data_chb_o);
            end
         end
         prev_valid = valid_o;
      end
   end

   // --------------------
   // main sequence
   initial begin
      adc_lvds_pkg::word_t wa;
      adc_lvds_pkg::word_t wb;
      int                  last_cyc;
      rst     = 1'b1;
      fclk_i  = 1'b0;
      da0_e_i = 1'b0;
      da0_o_i = 1'b0;
      da1_e_i = 1'b0;
      da1_o_i = 1'b0;
      db0_e_i = 1'b0;
      db0_o_i = 1'b0;
      db1_e_i = 1'b0;
      db1_o_i = 1'b0;
      build_table();
      for (int i = 0; i < 2; i++) begin
         exp_a_q.push_back('0);             // pipeline still holds idle words
         exp_b_q.push_back('0);
      end
      for (int i = 0; i < tbl_n; i++) begin
         exp_a_q.push_back(tbl_a[i]);
         exp_b_q.push_back(tbl_b[i]);
      end
      for (int i = 0; i < reset_cycles; i++) begin
         @(negedge adc_dclk);
         if (valid_o !== 1'b0) begin
            protocol_errors++;
            $display("[ERROR] %0t valid_o expected 0 got %b", $time, valid_o);
         end
         if (data_cha_o !== '0 || data_chb_o !== '0) begin
            data_errors++;
            $display("[ERROR] %0t data_cha_o/data_chb_o expected 0000/0000 got %h/%h",
                     $time, data_cha_o, data_chb_o);
         end
      end
      rst = 1'b0;
      for (int i = 0; i < n_words; i++) begin
         wa = '0;
         wb = '0;
         if (i < tbl_n) begin
            wa = tbl_a[i];
            wb = tbl_b[i];
         end
         send_word(wa, wb, last_cyc);
         if (i < tbl_n) begin
            word_end[i] = last_cyc;
         end
      end
      wait (pulses == n_words);
      repeat (latency + 2) @(negedge adc_dclk);   // room for any stray pulse
      if (pulses != changes) begin
         protocol_errors++;
         $display("%0d valid pulses for %0d fclk changes", pulses, changes);
      end
      $display("errors: data %0d, timing %0d, protocol %0d",
               data_errors, timing_errors, protocol_errors);
      if (data_errors + timing_errors + protocol_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (cyc >= timeout_cycles);
      $display("timeout after %0d cycles, only %0d of %0d pulses seen",
               cyc, pulses, n_words);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: adc3663_lvds_rx.f
rtl/adc_lvds_pkg.sv
rtl/frame_edge_decode.sv
rtl/lane_word_assembler.sv
rtl/frame_word_result.sv
rtl/adc3663_lvds_rx.sv
verification/adc3663_lvds_rx_tb.sv

// File: Makefile
# Verilator build and run for the adc3663 lvds receive path

VERILATOR ?= verilator
TOP       ?= adc3663_lvds_rx_tb
FILELIST  ?= adc3663_lvds_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT := Verification passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG) VFLAGS='$(VFLAGS)'"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "test PASSED"; \
	else \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
